// File: design/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths.
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_STRB_W 8

// 1024 words of 64 bits, mapped at the start of the core's RAM window.
`define MEM_DEPTH_LOG2 10
`define MEM_BASE 32'h8000_0000

// write and read response codes.
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

// File: design/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

  // one data word, viewed either as byte lanes or as 32-bit halves.
  typedef union packed {
    logic [`MEM_STRB_W-1:0][7:0] bytes;
    logic [1:0][31:0] halves;
  } mem_word_u;

endpackage

// File: design/axi_wr_capture.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_wr_capture import mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   awvalid,
  input  logic                   awready,
  input  logic [`MEM_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  input  logic                   wready,
  input  mem_word_u              wdata,
  input  logic [`MEM_STRB_W-1:0] wstrb,
  input  logic                   wr_done,
  output logic                   wr_pending,
  output logic [`MEM_ADDR_W-1:0] wr_addr,
  output mem_word_u              wr_data,
  output logic [`MEM_STRB_W-1:0] wr_strb
);

  logic addr_held;
  logic data_held;
  logic aw_fire;
  logic w_fire;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  // address and data arrive on their own schedule.
  always_ff @(posedge clk) begin
    if (rstn) begin
      addr_held <= 1'b0;
      data_held <= 1'b0;
    end else begin
      if (aw_fire) begin
        addr_held <= 1'b1;
      end else if (wr_done) begin
        addr_held <= 1'b0;
      end
      if (w_fire) begin
        data_held <= 1'b1;
      end else if (wr_done) begin
        data_held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_addr <= awaddr;
    end
    if (w_fire) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
  end

  assign wr_pending = addr_held & data_held;

endmodule

// File: design/mem_array.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_array import mem_pkg::*; (
  input  logic                       clk,
  input  logic                       ram_en,
  input  logic                       ram_we,
  input  logic [`MEM_DEPTH_LOG2-1:0] ram_addr,
  input  mem_word_u                  wr_data,
  input  logic [`MEM_STRB_W-1:0]     wr_strb,
  output mem_word_u                  rd_data
);

  localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

  mem_word_u mem [DEPTH];

  // one port serves either a masked write or a registered read per cycle.
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        for (int i = 0; i < `MEM_STRB_W; i++) begin
          if (wr_strb[i]) begin
            mem[ram_addr].bytes[i] <= wr_data.bytes[i];
          end
        end
      end else begin
        rd_data <= mem[ram_addr];
      end
    end
  end

endmodule

// File: design/rd_resp_fifo.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module rd_resp_fifo import mem_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rd_push,
  input  logic       rd_err,
  input  mem_word_u  rd_data,
  input  logic       rready,
  output logic       rvalid,
  output mem_word_u  rdata,
  output logic [1:0] rresp,
  output logic [1:0] fifo_space
);

  mem_word_u  data_q [2];
  logic [1:0] resp_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       pop;

  assign pop = rvalid & rready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (rd_push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + 2'(rd_push) - 2'(pop);
    end
  end

  // an out-of-range read carries zero data.
  always_ff @(posedge clk) begin
    if (rd_push) begin
      data_q[wr_ptr] <= rd_err ? mem_word_u'('0) : rd_data;
      resp_q[wr_ptr] <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
    end
  end

  assign rvalid     = (count != 2'd0);
  assign rdata      = data_q[rd_ptr];
  assign rresp      = resp_q[rd_ptr];
  assign fifo_space = 2'd2 - count;

endmodule

// File: design/mem_ctrl.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_ctrl (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       awvalid,
  input  logic                       wvalid,
  input  logic                       arvalid,
  input  logic [`MEM_ADDR_W-1:0]     araddr,
  input  logic                       wr_pending,
  input  logic [`MEM_ADDR_W-1:0]     wr_addr,
  input  logic [1:0]                 fifo_space,
  input  logic                       bready,
  output logic                       awready,
  output logic                       wready,
  output logic                       arready,
  output logic                       bvalid,
  output logic [1:0]                 bresp,
  output logic                       ram_en,
  output logic                       ram_we,
  output logic [`MEM_DEPTH_LOG2-1:0] ram_addr,
  output logic                       wr_done,
  output logic                       rd_push,
  output logic                       rd_err
);

  localparam int OFF_W = `MEM_DEPTH_LOG2 + 3;

  // anything outside the window, including below the base, wraps to a large offset.
  function automatic logic out_of_range(input logic [`MEM_ADDR_W-1:0] addr);
    logic [`MEM_ADDR_W-1:0] off;
    off = addr - `MEM_BASE;
    return off[`MEM_ADDR_W-1:OFF_W] != '0;
  endfunction

  logic                       rd_pend_q;
  logic                       rd_oor_q;
  logic [`MEM_DEPTH_LOG2-1:0] rd_idx_q;
  logic                       rd_issue_q;
  logic                       rd_err_q;
  logic [1:0]                 rd_cnt;
  logic                       last_wr;

  logic aw_fire;
  logic w_fire;
  logic ar_fire;
  logic b_fire;
  logic wr_oor;
  logic ram_wr_req;
  logic ram_rd_req;
  logic wr_grant;
  logic rd_grant;
  logic rd_issue;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign ar_fire = arvalid & arready;
  assign b_fire  = bvalid & bready;

  // out-of-range accesses never touch the RAM.
  assign wr_oor     = out_of_range(wr_addr);
  assign ram_wr_req = wr_pending & ~wr_oor;
  assign ram_rd_req = rd_pend_q & ~rd_oor_q;

  // on a conflict, the side that lost last time wins.
  assign wr_grant = ram_wr_req & (~ram_rd_req | ~last_wr);
  assign rd_grant = ram_rd_req & ~wr_grant;

  assign wr_done  = wr_pending & (wr_oor | wr_grant);
  assign rd_issue = rd_pend_q & (rd_oor_q | rd_grant);

  assign ram_en   = wr_grant | rd_grant;
  assign ram_we   = wr_grant;
  assign ram_addr = wr_grant ? wr_addr[OFF_W-1:3] : rd_idx_q;

  // never accept more reads than the queue can still take.
  assign arready = (fifo_space > rd_cnt) & (~rd_pend_q | rd_issue);

  assign rd_push = rd_issue_q;
  assign rd_err  = rd_err_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      awready    <= 1'b1;
      wready     <= 1'b1;
      bvalid     <= 1'b0;
      rd_pend_q  <= 1'b0;
      rd_issue_q <= 1'b0;
      rd_cnt     <= 2'd0;
      last_wr    <= 1'b0;
    end else begin
      if (aw_fire) begin
        awready <= 1'b0;
      end else if (b_fire) begin
        awready <= 1'b1;
      end
      if (w_fire) begin
        wready <= 1'b0;
      end else if (b_fire) begin
        wready <= 1'b1;
      end
      if (wr_done) begin
        bvalid <= 1'b1;
      end else if (b_fire) begin
        bvalid <= 1'b0;
      end
      if (ar_fire) begin
        rd_pend_q <= 1'b1;
      end else if (rd_issue) begin
        rd_pend_q <= 1'b0;
      end
      rd_issue_q <= rd_issue;
      rd_cnt     <= rd_cnt + 2'(ar_fire) - 2'(rd_push);
      if (wr_grant) begin
        last_wr <= 1'b1;
      end else if (rd_grant) begin
        last_wr <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_idx_q <= araddr[OFF_W-1:3];
      rd_oor_q <= out_of_range(araddr);
    end
    if (rd_issue) begin
      rd_err_q <= rd_oor_q;
    end
    if (wr_done) begin
      bresp <= wr_oor ? `RESP_SLVERR : `RESP_OKAY;
    end
  end

endmodule

// File: design/axi_mem_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_mem_top import mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [`MEM_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [`MEM_DATA_W-1:0] wdata,
  input  logic [`MEM_STRB_W-1:0] wstrb,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [`MEM_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [`MEM_DATA_W-1:0] rdata,
  output logic [1:0]             rresp
);

  logic                       wr_pending;
  logic [`MEM_ADDR_W-1:0]     wr_addr;
  mem_word_u                  wr_data;
  logic [`MEM_STRB_W-1:0]     wr_strb;
  logic                       wr_done;
  logic                       ram_en;
  logic                       ram_we;
  logic [`MEM_DEPTH_LOG2-1:0] ram_addr;
  mem_word_u                  rd_data;
  logic                       rd_push;
  logic                       rd_err;
  logic [1:0]                 fifo_space;

  mem_ctrl mem_ctrl_i (
    .clk        (clk),
    .rstn       (rstn),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .wr_pending (wr_pending),
    .wr_addr    (wr_addr),
    .fifo_space (fifo_space),
    .bready     (bready),
    .awready    (awready),
    .wready     (wready),
    .arready    (arready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .wr_done    (wr_done),
    .rd_push    (rd_push),
    .rd_err     (rd_err)
  );

  axi_wr_capture axi_wr_capture_i (
    .clk        (clk),
    .rstn       (rstn),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wr_done    (wr_done),
    .wr_pending (wr_pending),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb)
  );

  mem_array mem_array_i (
    .clk      (clk),
    .ram_en   (ram_en),
    .ram_we   (ram_we),
    .ram_addr (ram_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb),
    .rd_data  (rd_data)
  );

  rd_resp_fifo rd_resp_fifo_i (
    .clk        (clk),
    .rstn       (rstn),
    .rd_push    (rd_push),
    .rd_err     (rd_err),
    .rd_data    (rd_data),
    .rready     (rready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rresp      (rresp),
    .fifo_space (fifo_space)
  );

endmodule

// File: verif/axi_mem_chk.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_mem_chk (
  input logic                   clk,
  input logic                   rstn,
  input logic                   awready,
  input logic                   wready,
  input logic                   bvalid,
  input logic                   bready,
  input logic [1:0]             bresp,
  input logic                   arvalid,
  input logic                   arready,
  input logic                   rvalid,
  input logic                   rready,
  input logic [`MEM_DATA_W-1:0] rdata,
  input logic [1:0]             rresp
);

  int unsigned fail_count = 0;
  logic [2:0]  rd_out;

  // reads accepted on ar but not yet returned on r.
  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_out <= 3'd0;
    end else begin
      rd_out <= rd_out + 3'(arvalid && arready) - 3'(rvalid && rready);
    end
  end

  a_reset_state: assert property (@(posedge clk)
    rstn |=> (!rvalid && !bvalid && awready && wready && arready))
    else begin
      $error("outputs not idle after reset");
      fail_count++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (rstn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("b response dropped before bready");
      fail_count++;
    end

  // aw and w stay closed while a response waits.
  a_one_b: assert property (@(posedge clk) disable iff (rstn)
    bvalid |-> !awready && !wready)
    else begin
      $error("write channel open during b response");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("r data changed before rready");
      fail_count++;
    end

  a_rd_limit: assert property (@(posedge clk) disable iff (rstn)
    rd_out <= 3'd2)
    else begin
      $error("more than two reads in flight");
      fail_count++;
    end

  a_ar_full: assert property (@(posedge clk) disable iff (rstn)
    rd_out == 3'd2 |-> !arready)
    else begin
      $error("arready high with full read queue");
      fail_count++;
    end

endmodule

bind axi_mem_top axi_mem_chk axi_mem_chk_i (.*);

// File: verif/axi_mem_tb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_mem_tb import mem_pkg::*; ();

  localparam int N_INIT = 16;
  localparam int N_WR = 40;
  localparam int N_OOR = 4;
  localparam int N_RD = 60;
  localparam int N_TRANS = N_INIT * 2 + N_WR + N_OOR + N_RD;
  localparam int CYCLE_LIMIT = 10 * N_TRANS + 200;

  logic                   clk;
  logic                   rstn;
  logic                   awvalid;
  logic                   awready;
  logic [`MEM_ADDR_W-1:0] awaddr;
  logic                   wvalid;
  logic                   wready;
  logic [`MEM_DATA_W-1:0] wdata;
  logic [`MEM_STRB_W-1:0] wstrb;
  logic                   bvalid;
  logic                   bready;
  logic [1:0]             bresp;
  logic                   arvalid;
  logic                   arready;
  logic [`MEM_ADDR_W-1:0] araddr;
  logic                   rvalid;
  logic                   rready;
  logic [`MEM_DATA_W-1:0] rdata;
  logic [1:0]             rresp;

  logic [31:0] lfsr = 32'd73;
  int          cycles = 0;
  int          rcv_count = 0;
  mem_word_u   ref_mem [16];
  mem_word_u   exp_data_q [$];
  logic [1:0]  exp_resp_q [$];

  axi_mem_top axi_mem_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_now();
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic wrong_value(input string sig, input logic [63:0] exp, input logic [63:0] act);
    $display("Mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
    fail_now();
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // mode 0 sends the address first, 1 the data first, 2 both together.
  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input logic [1:0] mode, input logic oor);
    logic aw_done;
    logic w_done;
    logic aw_hit;
    logic w_hit;
    logic b_hit;
    aw_done = 1'b0;
    w_done = 1'b0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = (mode != 2'd1);
    wvalid = (mode != 2'd0);
    while (!(aw_done && w_done)) begin
      aw_hit = awvalid && awready;
      w_hit = wvalid && wready;
      step();
      if (aw_hit) begin
        aw_done = 1'b1;
        awvalid = 1'b0;
        wvalid = !w_done && !w_hit;
      end
      if (w_hit) begin
        w_done = 1'b1;
        wvalid = 1'b0;
        awvalid = !aw_done;
      end
    end
    if (!oor) begin
      for (int i = 0; i < 8; i++) begin
        if (strb[i]) begin
          ref_mem[addr[6:3]].bytes[i] = data[i*8 +: 8];
        end
      end
    end
    b_hit = 1'b0;
    while (!b_hit) begin
      bready = rand_bits(1) == 64'd1;
      b_hit = bvalid && bready;
      if (b_hit && bresp !== (oor ? `RESP_SLVERR : `RESP_OKAY)) begin
        wrong_value("bresp", 64'(oor ? `RESP_SLVERR : `RESP_OKAY), 64'(bresp));
      end
      step();
    end
    bready = 1'b0;
  endtask

  task automatic run_reads(input int n, input logic stall, input logic allow_oor);
    int          issued;
    int          start;
    logic        oor;
    logic        ar_hit;
    logic [31:0] addr;
    issued = 0;
    start = rcv_count;
    oor = 1'b0;
    while (rcv_count - start < n) begin
      if (!arvalid && issued < n) begin
        oor = allow_oor && rand_bits(3) == 64'd0;
        addr = oor ? 32'h0000_1000 : `MEM_BASE + {25'd0, 4'(rand_bits(4)), 3'd0};
        araddr = addr;
        arvalid = 1'b1;
      end
      rready = stall ? rand_bits(1) == 64'd1 : 1'b1;
      ar_hit = arvalid && arready;
      if (ar_hit) begin
        exp_data_q.push_back(oor ? mem_word_u'('0) : ref_mem[araddr[6:3]]);
        exp_resp_q.push_back(oor ? `RESP_SLVERR : `RESP_OKAY);
        issued++;
      end
      step();
      if (ar_hit) begin
        arvalid = 1'b0;
      end
    end
    rready = 1'b0;
  endtask

  always @(posedge clk) begin : r_monitor
    mem_word_u  exp_w;
    mem_word_u  act_w;
    logic [1:0] exp_r;
    if (!rstn && rvalid && rready) begin
      if (exp_data_q.size() == 0) begin
        $display("Read response at %0t with no read outstanding", $time);
        fail_now();
      end
      exp_w = exp_data_q.pop_front();
      exp_r = exp_resp_q.pop_front();
      act_w = rdata;
      if (act_w.halves[0] !== exp_w.halves[0]) begin
        wrong_value("rdata[31:0]", 64'(exp_w.halves[0]), 64'(act_w.halves[0]));
      end
      if (act_w.halves[1] !== exp_w.halves[1]) begin
        wrong_value("rdata[63:32]", 64'(exp_w.halves[1]), 64'(act_w.halves[1]));
      end
      if (rresp !== exp_r) begin
        wrong_value("rresp", 64'(exp_r), 64'(rresp));
      end
      rcv_count++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles", cycles);
      fail_now();
    end
  end

  initial begin : stimulus
    logic [1:0] mode;
    rstn = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    repeat (5) @(posedge clk);
    #1 rstn = 1'b0;
    // every word in the test window gets a known value first.
    for (int i = 0; i < N_INIT; i++) begin
      do_write(`MEM_BASE + 32'(i) * 32'd8, rand_bits(64), 8'hFF, 2'(i % 3), 1'b0);
    end
    run_reads(N_INIT, 1'b0, 1'b0);
    for (int i = 0; i < N_WR; i++) begin
      mode = 2'(rand_bits(2));
      if (mode == 2'd3) begin
        mode = 2'd2;
      end
      do_write(`MEM_BASE + {25'd0, 4'(rand_bits(4)), 3'd0}, rand_bits(64),
               8'(rand_bits(8)), mode, 1'b0);
    end
    for (int i = 0; i < N_OOR; i++) begin
      do_write(`MEM_BASE + 32'h2000 + {25'd0, 4'(rand_bits(4)), 3'd0}, rand_bits(64),
               8'hFF, 2'(i % 3), 1'b1);
    end
    run_reads(N_RD, 1'b1, 1'b1);
    step();
    step();
    if (rvalid !== 1'b0 || bvalid !== 1'b0 ||
        axi_mem_top_i.axi_mem_chk_i.fail_count != 0) begin
      $display("Response left pending after the last transfer or protocol checks failed");
      fail_now();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: axi_mem.f
+incdir+design
design/mem_pkg.sv
design/axi_wr_capture.sv
design/mem_array.sv
design/rd_resp_fifo.sv
design/mem_ctrl.sv
design/axi_mem_top.sv
verif/axi_mem_chk.sv
verif/axi_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f axi_mem.f --top-module axi_mem_tb -o axi_mem_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/axi_mem_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
else
  exit 1
fi
